// ==== rtl/recoveryPkg.sv ====
// ##############################
// Active-list pointer and execution state types
// Flush range struct and the selective-flush check
// ##############################

package recoveryPkg;

    localparam int activeListSize = 32;

    // Index into the active list
    typedef logic [4:0] activeListPtr;

    // Per-entry completion state
    typedef enum logic {
        execNotFinished = 1'b0,
        execSuccess     = 1'b1
    } execState;

    // Flush request from the recovery logic
    typedef struct packed {
        logic         active;
        logic         flushAll;
        activeListPtr headPtr;
        activeListPtr tailPtr;
    } flushRange;

    // True when the op at ptr falls inside the flushed part of the active list.
    // The range runs from headPtr up to but not including tailPtr, wrapping at 32
    function automatic logic isFlushed(flushRange range, activeListPtr ptr);
        logic inRange;
        if (range.headPtr <= range.tailPtr) begin
            inRange = (ptr >= range.headPtr) && (ptr < range.tailPtr);
        end
        else begin
            // Wrapped range
            inRange = (ptr >= range.headPtr) || (ptr < range.tailPtr);
        end
        return range.active && (range.flushAll || inRange);
    endfunction

endpackage

// ==== rtl/complexOpPkg.sv ====
// ##############################
// Data widths and operand types
// Multiply op codes, issued-op and lane-write structs
// ##############################

package complexOpPkg;

    localparam int dataWidth     = 32;
    localparam int physRegCount  = 64;

    typedef logic [dataWidth-1:0]   dataWord;
    typedef logic [2*dataWidth-1:0] productWord;

    // Physical register number, 64 registers
    typedef logic [5:0] physRegNum;

    // Low product, then the three high-product variants
    typedef enum logic [1:0] {
        opMul    = 2'd0,
        opMulh   = 2'd1,
        opMulhu  = 2'd2,
        opMulhsu = 2'd3
    } complexOpCode;

    // One micro-op as handed over by the scheduler
    typedef struct packed {
        logic                      valid;
        complexOpCode              opCode;
        dataWord                   srcA;
        dataWord                   srcB;
        logic                      writeReg;
        physRegNum                 dstReg;
        recoveryPkg::activeListPtr alPtr;
    } issuedOp;

    // Register file and active list write from one lane
    typedef struct packed {
        logic                      regWe;
        physRegNum                 dstReg;
        dataWord                   data;
        logic                      alWe;
        recoveryPkg::activeListPtr alPtr;
    } laneWrite;

endpackage

// ==== rtl/complexIssueLatch.sv ====
// ##############################
// Issue register stage for all lanes
// ##############################

`timescale 1ns/1ps

module complexIssueLatch #(
    parameter int laneCount = 2
) (
    input  logic                 ctrl,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 clear,
    input  complexOpPkg::issuedOp issue     [laneCount],
    output complexOpPkg::issuedOp latchedOp [laneCount]
);

    logic                  validReg   [laneCount];
    complexOpPkg::issuedOp payloadReg [laneCount];

    // Valid bits, cleared by reset and by clear
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < laneCount; i++) begin
                validReg[i] <= 1'b0;
            end
        end
        else if (!stall) begin
            for (int i = 0; i < laneCount; i++) begin
                validReg[i] <= issue[i].valid && !clear;
            end
        end
    end

    // Operands and control fields
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            payloadReg <= issue;
        end
    end

    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            latchedOp[i]       = payloadReg[i];
            latchedOp[i].valid = validReg[i];
        end
    end

    // The scheduler must never hand the same active-list entry to two lanes
    for (genvar i = 0; i < laneCount; i++) begin : gPairA
        for (genvar j = i + 1; j < laneCount; j++) begin : gPairB
            assert property (@(posedge ctrl) disable iff (!arstN)
                (!stall && issue[i].valid && issue[j].valid)
                    |-> (issue[i].alPtr != issue[j].alPtr))
                else $error("lanes %0d and %0d issued with the same alPtr", i, j);
        end
    end

endmodule

// ==== rtl/complexIntLane.sv ====
// ##############################
// One multiply lane
// Two multiply stages, register-write stage
// with selective flush filtering
// ##############################

`timescale 1ns/1ps

module complexIntLane (
    input  logic                   ctrl,
    input  logic                   arstN,
    input  logic                   stall,
    input  logic                   clear,
    input  recoveryPkg::flushRange recovery,
    input  complexOpPkg::issuedOp  op,
    output complexOpPkg::laneWrite laneWr
);

    // Write-stage payload: the product plus what the write needs
    typedef struct packed {
        complexOpPkg::complexOpCode opCode;
        logic                       writeReg;
        complexOpPkg::physRegNum    dstReg;
        recoveryPkg::activeListPtr  alPtr;
        complexOpPkg::productWord   product;
    } writeStageReg;

    logic                  s1Valid;
    complexOpPkg::issuedOp s1Op;

    logic                     signA;
    logic                     signB;
    logic signed [32:0]       aExt;
    logic signed [32:0]       bExt;
    logic signed [65:0]       fullProduct;
    complexOpPkg::productWord s1Product;

    logic         wsValid;
    writeStageReg wsReg;

    logic                  flush;
    logic                  update;
    complexOpPkg::dataWord resultWord;

    // Stage 1 register
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
        end
        else if (!stall) begin
            s1Valid <= op.valid && !clear;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            s1Op <= op;
        end
    end

    // Sign extension per op code, then one 33x33 signed multiply
    always_comb begin
        signA = (s1Op.opCode == complexOpPkg::opMulh) ||
                (s1Op.opCode == complexOpPkg::opMulhsu);
        signB = (s1Op.opCode == complexOpPkg::opMulh);
        aExt  = {signA && s1Op.srcA[31], s1Op.srcA};
        bExt  = {signB && s1Op.srcB[31], s1Op.srcB};
    end

    assign fullProduct = aExt * bExt;
    assign s1Product   = fullProduct[63:0];

    // Write-stage register
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            wsValid <= 1'b0;
        end
        else if (!stall) begin
            wsValid <= s1Valid && !clear;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            wsReg.opCode   <= s1Op.opCode;
            wsReg.writeReg <= s1Op.writeReg;
            wsReg.dstReg   <= s1Op.dstReg;
            wsReg.alPtr    <= s1Op.alPtr;
            wsReg.product  <= s1Product;
        end
    end

    // Register write: drop the op on stall, clear or a matching flush
    always_comb begin
        flush  = recoveryPkg::isFlushed(recovery, wsReg.alPtr);
        update = !stall && !clear && wsValid && !flush;

        if (wsReg.opCode == complexOpPkg::opMul) begin
            resultWord = wsReg.product[31:0];
        end
        else begin
            resultWord = wsReg.product[63:32];
        end

        laneWr.regWe  = update && wsReg.writeReg;
        laneWr.dstReg = wsReg.dstReg;
        laneWr.data   = resultWord;
        laneWr.alWe   = update;
        laneWr.alPtr  = wsReg.alPtr;
    end

    // A flush-all request is only meaningful with the flush active
    assert property (@(posedge ctrl) disable iff (!arstN)
        recovery.flushAll |-> recovery.active)
        else $error("recovery flushAll raised without active");

endmodule

// ==== rtl/writebackCollector.sv ====
// ##############################
// Physical register file and
// active-list finished table
// One write port per lane, read ports
// ##############################

`timescale 1ns/1ps

module writebackCollector #(
    parameter int laneCount = 2
) (
    input  logic                      ctrl,
    input  logic                      arstN,
    input  complexOpPkg::laneWrite    laneWr [laneCount],
    input  logic                      allocValid,
    input  recoveryPkg::activeListPtr allocPtr,
    input  complexOpPkg::physRegNum   regReadNum,
    output complexOpPkg::dataWord     regReadData,
    input  recoveryPkg::activeListPtr alReadPtr,
    output recoveryPkg::execState     alReadState
);

    complexOpPkg::dataWord regFile [complexOpPkg::physRegCount];
    recoveryPkg::execState alState [recoveryPkg::activeListSize];

    // Register file, zeroed on reset
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < complexOpPkg::physRegCount; r++) begin
                regFile[r] <= '0;
            end
        end
        else begin
            for (int i = 0; i < laneCount; i++) begin
                if (laneWr[i].regWe) begin
                    regFile[laneWr[i].dstReg] <= laneWr[i].data;
                end
            end
        end
    end

    // Finished table
    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int e = 0; e < recoveryPkg::activeListSize; e++) begin
                alState[e] <= recoveryPkg::execNotFinished;
            end
        end
        else begin
            for (int i = 0; i < laneCount; i++) begin
                if (laneWr[i].alWe) begin
                    alState[laneWr[i].alPtr] <= recoveryPkg::execSuccess;
                end
            end
            // Dispatch comes last so it wins over a completion
            if (allocValid) begin
                alState[allocPtr] <= recoveryPkg::execNotFinished;
            end
        end
    end

    assign regReadData = regFile[regReadNum];
    assign alReadState = alState[alReadPtr];

    // Lanes never collide on a destination register
    for (genvar i = 0; i < laneCount; i++) begin : gPairA
        for (genvar j = i + 1; j < laneCount; j++) begin : gPairB
            assert property (@(posedge ctrl) disable iff (!arstN)
                (laneWr[i].regWe && laneWr[j].regWe)
                    |-> (laneWr[i].dstReg != laneWr[j].dstReg))
                else $error("lanes %0d and %0d write register %0d together",
                            i, j, laneWr[i].dstReg);
        end
    end

endmodule

// ==== rtl/complexIntTop.sv ====
// ##############################
// Multiply back end top level
// Issue latch, lane array, collector
// ##############################

`timescale 1ns/1ps

module complexIntTop #(
    parameter int laneCount = 2
) (
    input  logic                      ctrl,
    input  logic                      arstN,
    input  logic                      stall,
    input  logic                      clear,
    input  recoveryPkg::flushRange    recovery,
    input  complexOpPkg::issuedOp     issue [laneCount],
    input  logic                      allocValid,
    input  recoveryPkg::activeListPtr allocPtr,
    input  complexOpPkg::physRegNum   regReadNum,
    output complexOpPkg::dataWord     regReadData,
    input  recoveryPkg::activeListPtr alReadPtr,
    output recoveryPkg::execState     alReadState
);

    complexOpPkg::issuedOp  latchedOp [laneCount];
    complexOpPkg::laneWrite laneWr    [laneCount];

    complexIssueLatch #(
        .laneCount (laneCount)
    ) issueLatch (
        .ctrl      (ctrl),
        .arstN     (arstN),
        .stall     (stall),
        .clear     (clear),
        .issue     (issue),
        .latchedOp (latchedOp)
    );

    for (genvar i = 0; i < laneCount; i++) begin : gLane
        complexIntLane lane (
            .ctrl     (ctrl),
            .arstN    (arstN),
            .stall    (stall),
            .clear    (clear),
            .recovery (recovery),
            .op       (latchedOp[i]),
            .laneWr   (laneWr[i])
        );
    end

    writebackCollector #(
        .laneCount (laneCount)
    ) collector (
        .ctrl        (ctrl),
        .arstN       (arstN),
        .laneWr      (laneWr),
        .allocValid  (allocValid),
        .allocPtr    (allocPtr),
        .regReadNum  (regReadNum),
        .regReadData (regReadData),
        .alReadPtr   (alReadPtr),
        .alReadState (alReadState)
    );

endmodule

// ==== test/complexIntTbUtil.svh ====
// ##############################
// LFSR operand source and reference multiply
// Typed compare tasks for the read ports
// ##############################

localparam logic [31:0] lfsrTaps = 32'h80200003;

// Galois LFSR, one step per bit taken
function automatic complexOpPkg::dataWord randomWord(inout logic [31:0] state);
    complexOpPkg::dataWord word;
    for (int b = 0; b < 32; b++) begin
        state = state[0] ? ((state >> 1) ^ lfsrTaps) : (state >> 1);
        word[b] = state[0];
    end
    return word;
endfunction

// Low half for opMul, high half of the extended product otherwise
function automatic complexOpPkg::dataWord refMul(complexOpPkg::complexOpCode opCode,
        complexOpPkg::dataWord a, complexOpPkg::dataWord b);
    logic [63:0] aSx;
    logic [63:0] bSx;
    logic [63:0] aZx;
    logic [63:0] bZx;
    logic [63:0] prod;
    aSx = {{32{a[31]}}, a};
    bSx = {{32{b[31]}}, b};
    aZx = {32'd0, a};
    bZx = {32'd0, b};
    case (opCode)
        complexOpPkg::opMulh:   prod = aSx * bSx;
        complexOpPkg::opMulhsu: prod = aSx * bZx;
        default:                prod = aZx * bZx;
    endcase
    if (opCode == complexOpPkg::opMul) begin
        return prod[31:0];
    end
    return prod[63:32];
endfunction

task automatic checkWord(string sigName, complexOpPkg::dataWord got,
        complexOpPkg::dataWord expected);
    if (got !== expected) begin
        $display("FAIL time=%0t %s got=%h expected=%h", $time, sigName, got, expected);
        failRun("result word mismatch");
    end
endtask

task automatic checkState(string sigName, recoveryPkg::execState got,
        recoveryPkg::execState expected);
    if (got !== expected) begin
        $display("FAIL time=%0t %s got=%s expected=%s", $time, sigName,
                 got.name(), expected.name());
        failRun("finished table mismatch");
    end
endtask

// ==== test/complexIntTb.sv ====
// ##############################
// Testbench for the multiply back end
// Stimulus table, applying loop, checks
// ##############################

`timescale 1ns/1ps

module complexIntTb;

    localparam int laneCount = 2;
    localparam int latency   = 3;
    localparam int pollLimit = 12;

    // One stimulus row, flushMode 0 none, 1 pointer range, 2 all
    typedef struct packed {
        logic                       lane;
        complexOpPkg::complexOpCode opCode;
        complexOpPkg::physRegNum    dstReg;
        recoveryPkg::activeListPtr  alPtr;
        logic [1:0]                 flushMode;
        recoveryPkg::activeListPtr  headPtr;
        recoveryPkg::activeListPtr  tailPtr;
        logic [2:0]                 stallCycles;
        logic                       clearIt;
        logic                       written;
    } stimEntry;

    // lane, op, dst, alPtr, flush mode, head, tail, stalls, clear, written
    localparam stimEntry stimTable [20] = '{
        '{1'b0, complexOpPkg::opMul,    6'd1,  5'd0,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulh,   6'd2,  5'd1,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulhu,  6'd3,  5'd2,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulhsu, 6'd4,  5'd3,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b1, complexOpPkg::opMul,    6'd5,  5'd4,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b1, complexOpPkg::opMulh,   6'd6,  5'd5,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b1, complexOpPkg::opMulhu,  6'd7,  5'd6,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        '{1'b1, complexOpPkg::opMulhsu, 6'd63, 5'd31, 2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1},
        // Range 8 to 12, wrapping range 28 to 2, flush all, empty range
        '{1'b0, complexOpPkg::opMulh,   6'd1,  5'd10, 2'd1, 5'd8,  5'd12, 3'd0, 1'b0, 1'b0},
        '{1'b1, complexOpPkg::opMul,    6'd2,  5'd12, 2'd1, 5'd8,  5'd12, 3'd0, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulhu,  6'd3,  5'd30, 2'd1, 5'd28, 5'd2,  3'd0, 1'b0, 1'b0},
        '{1'b1, complexOpPkg::opMulhsu, 6'd4,  5'd1,  2'd1, 5'd28, 5'd2,  3'd0, 1'b0, 1'b0},
        '{1'b0, complexOpPkg::opMul,    6'd5,  5'd20, 2'd1, 5'd28, 5'd2,  3'd0, 1'b0, 1'b1},
        '{1'b1, complexOpPkg::opMulh,   6'd6,  5'd13, 2'd2, 5'd0,  5'd0,  3'd0, 1'b0, 1'b0},
        '{1'b0, complexOpPkg::opMul,    6'd8,  5'd14, 2'd1, 5'd14, 5'd14, 3'd0, 1'b0, 1'b1},
        // Stalled ops, cleared ops, then a reused finished entry
        '{1'b1, complexOpPkg::opMulhu,  6'd9,  5'd15, 2'd0, 5'd0,  5'd0,  3'd4, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulhsu, 6'd1,  5'd16, 2'd0, 5'd0,  5'd0,  3'd2, 1'b0, 1'b1},
        '{1'b0, complexOpPkg::opMulh,   6'd2,  5'd17, 2'd0, 5'd0,  5'd0,  3'd0, 1'b1, 1'b0},
        '{1'b1, complexOpPkg::opMul,    6'd3,  5'd18, 2'd0, 5'd0,  5'd0,  3'd0, 1'b1, 1'b0},
        '{1'b0, complexOpPkg::opMul,    6'd10, 5'd0,  2'd0, 5'd0,  5'd0,  3'd0, 1'b0, 1'b1}
    };

    logic                      ctrl;
    logic                      arstN;
    logic                      stall;
    logic                      clear;
    recoveryPkg::flushRange    recovery;
    complexOpPkg::issuedOp     issue [laneCount];
    logic                      allocValid;
    recoveryPkg::activeListPtr allocPtr;
    complexOpPkg::physRegNum   regReadNum;
    complexOpPkg::dataWord     regReadData;
    recoveryPkg::activeListPtr alReadPtr;
    recoveryPkg::execState     alReadState;

    logic [31:0]           lfsrState;
    complexOpPkg::dataWord expReg [complexOpPkg::physRegCount];

    task automatic failRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on the first error");
    endtask

    `include "complexIntTbUtil.svh"

    complexIntTop #(.laneCount(laneCount)) uut (.*);

    initial begin
        ctrl = 1'b0;
        forever begin
            #20 ctrl = ~ctrl;
        end
    end

    // Every register and finished entry straight after reset
    task automatic checkResetState();
        for (int r = 0; r < complexOpPkg::physRegCount; r++) begin
            @(posedge ctrl);
            regReadNum <= complexOpPkg::physRegNum'(r);
            alReadPtr  <= recoveryPkg::activeListPtr'(r % recoveryPkg::activeListSize);
            @(negedge ctrl);
            checkWord("regReadData", regReadData, '0);
            checkState("alReadState", alReadState, recoveryPkg::execNotFinished);
        end
    endtask

    // Issue one row and follow it through the write stage
    task automatic applyEntry(stimEntry e);
        complexOpPkg::issuedOp op;
        complexOpPkg::dataWord expected;
        int                    edges;
        op.valid    = 1'b1;
        op.opCode   = e.opCode;
        op.srcA     = randomWord(lfsrState);
        op.srcB     = randomWord(lfsrState);
        op.writeReg = 1'b1;
        op.dstReg   = e.dstReg;
        op.alPtr    = e.alPtr;
        expected    = refMul(e.opCode, op.srcA, op.srcB);
        @(posedge ctrl);
        issue[e.lane]     <= op;
        recovery.active   <= (e.flushMode != 2'd0);
        recovery.flushAll <= (e.flushMode == 2'd2);
        recovery.headPtr  <= e.headPtr;
        recovery.tailPtr  <= e.tailPtr;
        allocValid        <= 1'b1;
        allocPtr          <= e.alPtr;
        regReadNum        <= e.dstReg;
        alReadPtr         <= e.alPtr;
        // Latch takes the op here, dispatch resets its entry
        @(posedge ctrl);
        issue[e.lane] <= '0;
        allocValid    <= 1'b0;
        stall         <= (e.stallCycles != 3'd0);
        clear         <= e.clearIt;
        for (int c = 0; c < int'(e.stallCycles); c++) begin
            @(posedge ctrl);
        end
        stall <= 1'b0;
        if (e.clearIt) begin
            @(posedge ctrl);
            clear <= 1'b0;
        end
        @(negedge ctrl);
        checkState("alReadState", alReadState, recoveryPkg::execNotFinished);
        if (e.written) begin
            edges = 0;
            while (alReadState != recoveryPkg::execSuccess) begin
                if (edges >= pollLimit) begin
                    failRun("timed out waiting for the op to finish");
                end
                @(posedge ctrl);
                edges++;
                @(negedge ctrl);
            end
            if (edges != latency) begin
                failRun($sformatf("op at alPtr %0d finished after %0d edges instead of %0d",
                                  e.alPtr, edges, latency));
            end
            expReg[e.dstReg] = expected;
        end
        else begin
            // Wait past the slot where a surviving op would have written
            for (int c = 0; c <= latency; c++) begin
                @(posedge ctrl);
            end
            @(negedge ctrl);
            checkState("alReadState", alReadState, recoveryPkg::execNotFinished);
        end
        checkWord("regReadData", regReadData, expReg[e.dstReg]);
    endtask

    initial begin
        lfsrState = 32'h1dbb;
        arstN      <= 1'b0;
        stall      <= 1'b0;
        clear      <= 1'b0;
        recovery   <= '0;
        allocValid <= 1'b0;
        allocPtr   <= '0;
        regReadNum <= '0;
        alReadPtr  <= '0;
        foreach (issue[i]) begin
            issue[i] <= '0;
        end
        foreach (expReg[r]) begin
            expReg[r] = '0;
        end
        repeat (8) begin
            @(posedge ctrl);
        end
        arstN <= 1'b1;
        checkResetState();
        for (int n = 0; n < $size(stimTable); n++) begin
            applyEntry(stimTable[n]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+test
rtl/recoveryPkg.sv
rtl/complexOpPkg.sv
rtl/complexIssueLatch.sv
rtl/complexIntLane.sv
rtl/writebackCollector.sv
rtl/complexIntTop.sv
test/complexIntTb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the multiply back end testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module complexIntTb -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi
./obj_dir/VcomplexIntTb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
